/* src/isa_pkg.sv */
`default_nettype none

package isa_pkg;

	// Word layout
	localparam int WORD_SIZE = 20;
	localparam int DATA_W = 16;
	localparam int TAG_W = WORD_SIZE - DATA_W;
	localparam int OPCODE_W = 5;
	localparam int SLOT_W = 2;

	typedef logic [WORD_SIZE-1:0] word_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [TAG_W-1:0] tag_t;

	// Word address with the slot number in the two low bits
	typedef logic [WORD_SIZE+SLOT_W-1:0] ip_t;

	typedef enum logic [OPCODE_W-1:0] {
		OP_NOP = 5'd0,
		OP_POP = 5'd3,
		OP_LOAD = 5'd4,
		OP_STORE = 5'd5,
		OP_ADD = 5'd6,
		OP_SUB = 5'd7,
		OP_GTR = 5'd9,
		OP_GTE = 5'd10,
		OP_EQ = 5'd11,
		OP_NEQ = 5'd12,
		OP_DUP = 5'd13,
		OP_AND = 5'd16,
		OP_OR = 5'd17,
		OP_XOR = 5'd18,
		OP_LSHIFT = 5'd19,
		OP_RSHIFT = 5'd20,
		OP_PUSH = 5'd25,
		OP_GOTO = 5'd26,
		OP_BFALSE = 5'd27
	} opcode_e;

	// Slot 3 has no bits left over for a parameter
	localparam logic [SLOT_W-1:0] LAST_SLOT = 2'd3;

	// Opcodes 24 and up take the rest of the word as their parameter
	function automatic logic has_param(opcode_e op);
		return op[OPCODE_W-1] && op[OPCODE_W-2];
	endfunction

endpackage

`default_nettype wire

/* src/core_pkg.sv */
`default_nettype none

package core_pkg;

	// Sequencer states
	typedef enum logic [2:0] {
		ST_IADDR_ISSUE,
		ST_DECODE,
		ST_GOT_NOS,
		ST_LOAD_TOS1,
		ST_PUSH_MEM_RESULT
	} state_e;

	// Next instruction pointer
	typedef enum logic [1:0] {
		IP_CURRENT,
		IP_NEXT,
		IP_BRANCH
	} ip_sel_e;

	// Next stack pointer
	typedef enum logic [1:0] {
		SP_CURRENT,
		SP_DEC,
		SP_INC
	} sp_sel_e;

	// Next top of stack
	typedef enum logic [1:0] {
		TOS_CURRENT,
		TOS_PARAM,
		TOS_ALU,
		TOS_MEM
	} tos_sel_e;

	// Memory port address
	typedef enum logic [1:0] {
		MA_IP,
		MA_SP,
		MA_TOS,
		MA_SP_MINUS_ONE
	} ma_sel_e;

	// Memory port write data
	typedef enum logic {
		MW_TOS,
		MW_MEM
	} mw_sel_e;

endpackage

`default_nettype wire

/* src/insn_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module insn_unit (
	input wire logic clk,
	input wire logic rst_n,
	input wire isa_pkg::word_t mem_read_value,
	input wire logic in_decode,
	input wire core_pkg::ip_sel_e ip_sel,
	output isa_pkg::opcode_e opcode,
	output isa_pkg::data_t param,
	output logic param_zero,
	output isa_pkg::data_t next_ip_word
);
	import isa_pkg::*;
	import core_pkg::*;

	ip_t ip;
	ip_t ip_next;
	word_t latched_word;
	word_t cur_word;
	logic [SLOT_W-1:0] slot;
	logic [WORD_SIZE-1:0] word_addr;
	logic [WORD_SIZE-1:0] branch_offset;

	// The fetched word is only on the read port during DECODE
	assign cur_word = in_decode ? mem_read_value : latched_word;
	assign slot = ip[SLOT_W-1:0];
	assign word_addr = ip[WORD_SIZE+SLOT_W-1:SLOT_W];

	// Slot alignment
	always_comb
	begin
		case (slot)
			2'd0:
			begin
				opcode = opcode_e'(cur_word[19:15]);
				param = {cur_word[14], cur_word[14:0]};
			end
			2'd1:
			begin
				opcode = opcode_e'(cur_word[14:10]);
				param = {{6{cur_word[9]}}, cur_word[9:0]};
			end
			2'd2:
			begin
				opcode = opcode_e'(cur_word[9:5]);
				param = {{11{cur_word[4]}}, cur_word[4:0]};
			end
			default:
			begin
				opcode = opcode_e'(cur_word[4:0]);
				param = '0;
			end
		endcase
	end

	assign param_zero = (param == '0);
	assign branch_offset = {{TAG_W{param[DATA_W-1]}}, param};

	always_comb
	begin
		case (ip_sel)
			IP_NEXT:
			begin
				// The parameter fills the rest of the word
				if (has_param(opcode))
					ip_next = {word_addr + 1'b1, 2'b00};
				else
					ip_next = ip + 1'b1;
			end
			IP_BRANCH:
				ip_next = {word_addr + branch_offset, 2'b00};
			default:
				ip_next = ip;
		endcase
	end

	assign next_ip_word = ip_next[DATA_W+SLOT_W-1:SLOT_W];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			// All ones so the first NEXT lands on word 0, slot 0
			ip <= '1;
			latched_word <= '0;
		end
		else
		begin
			ip <= ip_next;
			if (in_decode)
				latched_word <= mem_read_value;
		end
	end

	// A program never places a parameter opcode in the last slot
	assert property (@(posedge clk) disable iff (!rst_n)
		in_decode |-> !(has_param(opcode) && slot == LAST_SLOT));

endmodule

`default_nettype wire

/* src/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
	input wire isa_pkg::data_t a,
	input wire isa_pkg::data_t b,
	input wire isa_pkg::opcode_e alu_op,
	output isa_pkg::data_t result
);
	import isa_pkg::*;

	data_t diff;
	logic diff_zero;
	logic diff_neg;

	// Compares look at the sign and zero of the wrapped difference
	assign diff = a - b;
	assign diff_zero = (diff == '0);
	assign diff_neg = diff[DATA_W-1];

	always_comb
	begin
		case (alu_op)
			OP_ADD: result = a + b;
			OP_SUB: result = diff;
			OP_GTR: result = data_t'(!diff_neg && !diff_zero);
			OP_GTE: result = data_t'(!diff_neg);
			OP_EQ: result = data_t'(diff_zero);
			OP_NEQ: result = data_t'(!diff_zero);
			OP_AND: result = a & b;
			OP_OR: result = a | b;
			OP_XOR: result = a ^ b;
			// Shift counts of 16 or more clear the result
			OP_LSHIFT: result = a << b;
			OP_RSHIFT: result = a >> b;
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* src/stack_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module stack_datapath #(
	parameter int MEM_SIZE = 8192
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire core_pkg::sp_sel_e sp_sel,
	input wire core_pkg::tos_sel_e tos_sel,
	input wire core_pkg::ma_sel_e ma_sel,
	input wire core_pkg::mw_sel_e mw_sel,
	input wire isa_pkg::data_t param,
	input wire isa_pkg::data_t next_ip_word,
	input wire isa_pkg::word_t mem_read_value,
	input wire isa_pkg::data_t alu_result,
	output isa_pkg::data_t alu_a,
	output logic tos_zero,
	output isa_pkg::word_t memory_address,
	output isa_pkg::word_t mem_write_value
);
	import isa_pkg::*;
	import core_pkg::*;

	localparam data_t SP_RESET = data_t'(MEM_SIZE - 8);

	word_t tos;
	word_t tos_next;
	tag_t tos_tag;
	data_t sp;
	data_t sp_next;
	data_t sp_dec;
	data_t sp_inc;

	assign tos_tag = tos[WORD_SIZE-1:DATA_W];
	assign alu_a = tos[DATA_W-1:0];
	assign tos_zero = (alu_a == '0);
	assign sp_dec = sp - 1'b1;
	assign sp_inc = sp + 1'b1;

	always_comb
	begin
		case (tos_sel)
			// Immediates are sign-extended across the tag bits
			TOS_PARAM: tos_next = {{TAG_W{param[DATA_W-1]}}, param};
			TOS_ALU: tos_next = {tos_tag, alu_result};
			TOS_MEM: tos_next = mem_read_value;
			default: tos_next = tos;
		endcase
	end

	always_comb
	begin
		case (sp_sel)
			SP_DEC: sp_next = sp_dec;
			SP_INC: sp_next = sp_inc;
			default: sp_next = sp;
		endcase
	end

	always_comb
	begin
		case (ma_sel)
			MA_SP: memory_address = word_t'(sp);
			MA_TOS: memory_address = word_t'(alu_a);
			MA_SP_MINUS_ONE: memory_address = word_t'(sp_dec);
			default: memory_address = word_t'(next_ip_word);
		endcase
	end

	// Store writes the next-of-stack straight from the read port
	assign mem_write_value = (mw_sel == MW_MEM) ? mem_read_value : tos;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			tos <= '0;
			sp <= SP_RESET;
		end
		else
		begin
			tos <= tos_next;
			sp <= sp_next;
		end
	end

	// Popping past the bottom of the stack is a program error
	assert property (@(posedge clk) disable iff (!rst_n)
		sp <= SP_RESET);

endmodule

`default_nettype wire

/* src/control_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module control_fsm (
	input wire logic clk,
	input wire logic rst_n,
	input wire isa_pkg::opcode_e opcode,
	input wire logic param_zero,
	input wire logic tos_zero,
	output logic in_decode,
	output isa_pkg::opcode_e alu_op,
	output core_pkg::ip_sel_e ip_sel,
	output core_pkg::sp_sel_e sp_sel,
	output core_pkg::tos_sel_e tos_sel,
	output core_pkg::ma_sel_e ma_sel,
	output core_pkg::mw_sel_e mw_sel,
	output logic mem_write_enable
);
	import isa_pkg::*;
	import core_pkg::*;

	state_e state;
	state_e state_next;

	// Set while a bfalse finishes, its pointer is already final
	logic hold_ip;

	assign in_decode = (state == ST_DECODE);

	always_comb
	begin
		state_next = state;
		ip_sel = IP_CURRENT;
		sp_sel = SP_CURRENT;
		tos_sel = TOS_CURRENT;
		ma_sel = MA_IP;
		mw_sel = MW_TOS;
		mem_write_enable = 1'b0;
		alu_op = OP_NOP;

		case (state)
			ST_IADDR_ISSUE:
			begin
				ip_sel = IP_NEXT;
				state_next = ST_DECODE;
			end

			ST_DECODE:
			begin
				case (opcode)
					OP_PUSH, OP_DUP:
					begin
						// Spill the old top of stack below it
						ma_sel = MA_SP_MINUS_ONE;
						mw_sel = MW_TOS;
						mem_write_enable = 1'b1;
						sp_sel = SP_DEC;
						if (opcode == OP_PUSH)
							tos_sel = TOS_PARAM;
						state_next = ST_IADDR_ISSUE;
					end

					OP_POP:
					begin
						ma_sel = MA_SP;
						sp_sel = SP_INC;
						state_next = ST_PUSH_MEM_RESULT;
					end

					OP_LOAD:
					begin
						ma_sel = MA_TOS;
						state_next = ST_PUSH_MEM_RESULT;
					end

					OP_STORE, OP_ADD, OP_SUB, OP_GTR, OP_GTE, OP_EQ, OP_NEQ,
					OP_AND, OP_OR, OP_XOR, OP_LSHIFT, OP_RSHIFT:
					begin
						// Fetch the next-of-stack first
						ma_sel = MA_SP;
						state_next = ST_GOT_NOS;
					end

					OP_GOTO:
					begin
						// goto 0 is the halt idiom and spins in place from any slot
						ip_sel = param_zero ? IP_CURRENT : IP_BRANCH;
						state_next = ST_DECODE;
					end

					OP_BFALSE:
					begin
						ip_sel = tos_zero ? IP_BRANCH : IP_NEXT;
						ma_sel = MA_SP;
						sp_sel = SP_INC;
						state_next = ST_PUSH_MEM_RESULT;
					end

					default:
					begin
						ip_sel = IP_NEXT;
						state_next = ST_DECODE;
					end
				endcase
			end

			ST_GOT_NOS:
			begin
				sp_sel = SP_INC;
				if (opcode == OP_STORE)
				begin
					// Address in top of stack, value in next-of-stack
					ma_sel = MA_TOS;
					mw_sel = MW_MEM;
					mem_write_enable = 1'b1;
					state_next = ST_LOAD_TOS1;
				end
				else
				begin
					alu_op = opcode;
					tos_sel = TOS_ALU;
					ip_sel = IP_NEXT;
					state_next = ST_DECODE;
				end
			end

			ST_LOAD_TOS1:
			begin
				ma_sel = MA_SP;
				sp_sel = SP_INC;
				state_next = ST_PUSH_MEM_RESULT;
			end

			ST_PUSH_MEM_RESULT:
			begin
				tos_sel = TOS_MEM;
				ip_sel = hold_ip ? IP_CURRENT : IP_NEXT;
				state_next = ST_DECODE;
			end

			default:
				state_next = ST_IADDR_ISSUE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= ST_IADDR_ISSUE;
			hold_ip <= 1'b0;
		end
		else
		begin
			state <= state_next;
			if (state == ST_DECODE)
				hold_ip <= (opcode == OP_BFALSE);
		end
	end

	// Writes never land on a fetch cycle and never come back to back
	assert property (@(posedge clk) disable iff (!rst_n)
		mem_write_enable |-> (state != ST_IADDR_ISSUE) ##1 !mem_write_enable);

endmodule

`default_nettype wire

/* src/lisp_core.sv */
`timescale 1ns/1ps
`default_nettype none

module lisp_core #(
	parameter int MEM_SIZE = 8192
) (
	input wire logic clk,
	input wire logic rst_n,
	output isa_pkg::word_t memory_address,
	input wire isa_pkg::word_t mem_read_value,
	output isa_pkg::word_t mem_write_value,
	output logic mem_write_enable
);
	import isa_pkg::*;
	import core_pkg::*;

	opcode_e opcode;
	opcode_e alu_op;
	data_t param;
	data_t next_ip_word;
	data_t alu_a;
	data_t alu_b;
	data_t alu_result;
	logic param_zero;
	logic tos_zero;
	logic in_decode;
	ip_sel_e ip_sel;
	sp_sel_e sp_sel;
	tos_sel_e tos_sel;
	ma_sel_e ma_sel;
	mw_sel_e mw_sel;

	// Second operand is always the next-of-stack from the read port
	assign alu_b = mem_read_value[DATA_W-1:0];

	insn_unit insn_unit_i (
		.clk(clk),
		.rst_n(rst_n),
		.mem_read_value(mem_read_value),
		.in_decode(in_decode),
		.ip_sel(ip_sel),
		.opcode(opcode),
		.param(param),
		.param_zero(param_zero),
		.next_ip_word(next_ip_word)
	);

	control_fsm control_fsm_i (
		.clk(clk),
		.rst_n(rst_n),
		.opcode(opcode),
		.param_zero(param_zero),
		.tos_zero(tos_zero),
		.in_decode(in_decode),
		.alu_op(alu_op),
		.ip_sel(ip_sel),
		.sp_sel(sp_sel),
		.tos_sel(tos_sel),
		.ma_sel(ma_sel),
		.mw_sel(mw_sel),
		.mem_write_enable(mem_write_enable)
	);

	stack_datapath #(
		.MEM_SIZE(MEM_SIZE)
	) stack_datapath_i (
		.clk(clk),
		.rst_n(rst_n),
		.sp_sel(sp_sel),
		.tos_sel(tos_sel),
		.ma_sel(ma_sel),
		.mw_sel(mw_sel),
		.param(param),
		.next_ip_word(next_ip_word),
		.mem_read_value(mem_read_value),
		.alu_result(alu_result),
		.alu_a(alu_a),
		.tos_zero(tos_zero),
		.memory_address(memory_address),
		.mem_write_value(mem_write_value)
	);

	alu alu_i (
		.a(alu_a),
		.b(alu_b),
		.alu_op(alu_op),
		.result(alu_result)
	);

endmodule

`default_nettype wire

/* tests/tb_programs.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

function automatic word_t sext_word(int v);
	return word_t'(v);
endfunction

// LCG operand in the range of a slot 0 immediate
function automatic int rand15();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return int'(lcg_state[30:16]) - 16384;
endfunction

// Expected ALU result from the instruction-set rules
function automatic data_t alu_expect(opcode_e op, data_t a, data_t b);
	data_t d;
	d = a - b;
	case (op)
		OP_ADD: return a + b;
		OP_SUB: return d;
		OP_GTR: return (d[15] == 1'b0 && d != 16'h0) ? 16'h1 : 16'h0;
		OP_GTE: return (d[15] == 1'b0) ? 16'h1 : 16'h0;
		OP_EQ: return (d == 16'h0) ? 16'h1 : 16'h0;
		OP_NEQ: return (d != 16'h0) ? 16'h1 : 16'h0;
		OP_AND: return a & b;
		OP_OR: return a | b;
		OP_XOR: return a ^ b;
		OP_LSHIFT: return (b > 16'd15) ? 16'h0 : data_t'(a << b);
		OP_RSHIFT: return (b > 16'd15) ? 16'h0 : data_t'(a >> b);
		default: return 16'h0;
	endcase
endfunction

task automatic asm_begin();
	for (int i = 0; i < MEM_SIZE; i++)
		mem[i] = word_t'((i * 32'h2f3) ^ (i >> 3) ^ 32'h5a5a5);
	for (int i = 0; i < RES_SIZE; i++)
		exp_valid[i] = 1'b0;
	exp_cnt = 0;
	push_cnt = 0;
	asm_word = '0;
	asm_slot = 0;
	asm_addr = 0;
	live = 1'b1;
	model_sp = MEM_SIZE - 8;
endtask

task automatic flush_word();
	if (asm_slot != 0)
	begin
		mem[asm_addr] = asm_word;
		asm_addr++;
		asm_word = '0;
		asm_slot = 0;
	end
endtask

task automatic emit_op(opcode_e op);
	if (asm_slot == 4)
		flush_word();
	asm_word[19 - 5 * asm_slot -: 5] = op;
	asm_slot++;
endtask

// A parameter opcode uses up the rest of its word
task automatic emit_param(opcode_e op, int v);
	int w;
	int lim;
	if (asm_slot >= 3)
		flush_word();
	w = 15 - 5 * asm_slot;
	lim = 1 << (w - 1);
	if (v < -lim || v >= lim)
	begin
		flush_word();
		w = 15;
		lim = 1 << 14;
	end
	if (v < -lim || v >= lim)
		fail_msg("immediate does not fit in any slot");
	emit_op(op);
	asm_word = asm_word | (word_t'(v) & word_t'((1 << w) - 1));
	asm_slot = 4;
	flush_word();
endtask

task automatic stack_push();
	if (live)
	begin
		model_sp--;
		push_addr[push_cnt] = model_sp;
		push_cnt++;
	end
endtask

task automatic stack_pop(int n);
	if (live)
		model_sp += n;
endtask

task automatic op_push(int v);
	emit_param(OP_PUSH, v);
	stack_push();
endtask

task automatic op_dup();
	emit_op(OP_DUP);
	stack_push();
endtask

task automatic op_store_to(int off, word_t val);
	op_push(RES_BASE + off);
	emit_op(OP_STORE);
	stack_pop(2);
	if (live)
	begin
		exp_val[off] = val;
		exp_valid[off] = 1'b1;
		exp_cnt++;
	end
endtask

// Three words: push value, push address, store
task automatic store_block(int value, int off);
	op_push(value);
	op_store_to(off, sext_word(value));
	flush_word();
endtask

task automatic alu_case(opcode_e op, int a, int b, int off);
	op_push(b);
	op_push(a);
	emit_op(op);
	stack_pop(1);
	op_store_to(off, {(a < 0) ? 4'hf : 4'h0, alu_expect(op, data_t'(a), data_t'(b))});
endtask

task automatic finish_program(int id);
	op_push(id);
	op_store_to(DONE_OFF, sext_word(id));
	flush_word();
	emit_param(OP_GOTO, 0);
endtask

`endif

/* tests/tb_lisp_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lisp_core;
	import isa_pkg::*;

	localparam int MEM_SIZE = 8192;
	localparam int AW = $clog2(MEM_SIZE);
	localparam int RES_BASE = 'h1000;
	localparam int RES_SIZE = 256;
	localparam int DONE_OFF = 255;
	localparam int BAD_OFF = 128;
	localparam int STACK_FLOOR = MEM_SIZE - 256;
	localparam int TIMEOUT = 20000;

	logic clk;
	logic rst_n;
	word_t mem_read_value;
	word_t memory_address;
	word_t mem_write_value;
	logic mem_write_enable;

	word_t mem [0:MEM_SIZE-1];
	word_t read_q;

	// Expected result writes and stack push addresses
	word_t exp_val [0:RES_SIZE-1];
	bit exp_valid [0:RES_SIZE-1];
	int exp_cnt;
	int push_addr [0:255];
	int push_cnt;
	int push_idx;
	int res_writes;
	bit done_seen;
	bit [31:0] lcg_state;

	// Assembler state
	word_t asm_word;
	int asm_slot;
	int asm_addr;
	int model_sp;
	bit live;

	int wr_addr;
	logic in_res;
	logic in_stack;
	logic [7:0] res_idx;
	int push_exp;

	assign wr_addr = int'(memory_address);
	assign in_res = (wr_addr >= RES_BASE) && (wr_addr < RES_BASE + RES_SIZE);
	assign in_stack = (wr_addr >= STACK_FLOOR) && (wr_addr < MEM_SIZE);
	assign res_idx = memory_address[7:0];
	assign push_exp = push_addr[push_idx[7:0]];

	lisp_core #(
		.MEM_SIZE(MEM_SIZE)
	) lisp_core_i (
		.clk(clk),
		.rst_n(rst_n),
		.memory_address(memory_address),
		.mem_read_value(mem_read_value),
		.mem_write_value(mem_write_value),
		.mem_write_enable(mem_write_enable)
	);

	task automatic fail_value(string name, word_t got, word_t exp);
		$display("[FAIL] %s got %h expected %h", name, got, exp);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic fail_msg(string what);
		$display("ERROR: %s", what);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	`include "tb_programs.svh"

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Read data shows up in the cycle after the address
	always @(posedge clk)
	begin
		read_q <= mem[memory_address[AW-1:0]];
		if (mem_write_enable)
			mem[memory_address[AW-1:0]] = mem_write_value;
	end

	always @(negedge clk)
		mem_read_value = read_q;

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			push_idx <= 0;
			res_writes <= 0;
			done_seen <= 1'b0;
		end
		else if (mem_write_enable)
		begin
			if (in_stack)
				push_idx <= push_idx + 1;
			if (in_res)
				res_writes <= res_writes + 1;
			if (wr_addr == RES_BASE + DONE_OFF)
				done_seen <= 1'b1;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		mem_write_enable |-> (in_res || in_stack))
		else fail_msg("write outside the result and stack areas");

	assert property (@(posedge clk) disable iff (!rst_n)
		(mem_write_enable && in_res) |-> exp_valid[res_idx])
		else fail_msg("store to a result address that the program must not reach");

	assert property (@(posedge clk) disable iff (!rst_n)
		(mem_write_enable && in_res && exp_valid[res_idx]) |->
		(mem_write_value == exp_val[res_idx]))
		else fail_value("mem_write_value", $sampled(mem_write_value),
			exp_val[$sampled(res_idx)]);

	assert property (@(posedge clk) disable iff (!rst_n)
		(mem_write_enable && in_stack) |-> (push_idx < push_cnt))
		else fail_msg("more stack pushes than the program makes");

	assert property (@(posedge clk) disable iff (!rst_n)
		(mem_write_enable && in_stack && push_idx < push_cnt) |->
		(memory_address == word_t'(push_exp)))
		else fail_value("memory_address", $sampled(memory_address),
			word_t'($sampled(push_exp)));

	task automatic start_reset();
		@(negedge clk);
		rst_n = 1'b0;
		asm_begin();
	endtask

	task automatic release_and_wait(string name);
		int cycles;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		cycles = 0;
		while (!done_seen && cycles < TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!done_seen)
			fail_msg({name, " program never reached its final store"});
		else if (res_writes != exp_cnt)
			fail_msg({name, " program missed some of its result stores"});
		else if (push_idx != push_cnt)
			fail_msg({name, " program made fewer stack pushes than expected"});
		else
			$display("%s program done", name);
	endtask

	initial
	begin
		rst_n = 1'b0;
		mem_read_value = '0;
		lcg_state = 32'h6c25ccdf;

		// Push and store of values with both tag signs
		start_reset();
		store_block(-1234, 0);
		store_block(1234, 1);
		finish_program(1);
		release_and_wait("push-store");

		// Every kept ALU operation with a as the last push
		start_reset();
		alu_case(OP_ADD, rand15(), rand15(), 0);
		alu_case(OP_SUB, rand15(), rand15(), 1);
		alu_case(OP_GTR, rand15(), rand15(), 2);
		alu_case(OP_GTE, rand15(), rand15(), 3);
		alu_case(OP_EQ, rand15(), rand15(), 4);
		alu_case(OP_NEQ, rand15(), rand15(), 5);
		alu_case(OP_AND, rand15(), rand15(), 6);
		alu_case(OP_OR, rand15(), rand15(), 7);
		alu_case(OP_XOR, rand15(), rand15(), 8);
		alu_case(OP_LSHIFT, rand15(), rand15() & 31, 9);
		alu_case(OP_RSHIFT, rand15(), rand15() & 31, 10);
		alu_case(OP_EQ, 777, 777, 11);
		alu_case(OP_GTE, -50, -50, 12);
		alu_case(OP_GTR, -50, -50, 13);
		finish_program(2);
		release_and_wait("alu");

		// Packed slots
		start_reset();
		op_push(5);
		op_dup();
		emit_op(OP_NOP);
		op_dup();
		emit_op(OP_NOP);
		op_store_to(0, sext_word(5));
		flush_word();
		op_push(-12345);
		op_store_to(1, sext_word(-12345));
		flush_word();
		emit_op(OP_NOP);
		op_push(-300);
		op_store_to(2, sext_word(-300));
		flush_word();
		emit_op(OP_NOP);
		emit_op(OP_NOP);
		op_push(-9);
		op_store_to(3, sext_word(-9));
		finish_program(3);
		release_and_wait("packed");

		// Pop and dup
		start_reset();
		op_push(11);
		op_push(22);
		emit_op(OP_POP);
		stack_pop(1);
		op_store_to(0, sext_word(11));
		op_push(33);
		op_dup();
		op_store_to(1, sext_word(33));
		op_push(44);
		op_push(55);
		op_push(66);
		emit_op(OP_POP);
		stack_pop(1);
		emit_op(OP_POP);
		stack_pop(1);
		op_store_to(2, sext_word(44));
		finish_program(4);
		release_and_wait("stack");

		// Branches over a three-word marker block
		start_reset();
		flush_word();
		emit_param(OP_GOTO, 4);
		live = 1'b0;
		store_block(16'h0bad, BAD_OFF);
		live = 1'b1;
		store_block(16'h11, 0);
		op_push(0);
		emit_param(OP_BFALSE, 4);
		stack_pop(1);
		live = 1'b0;
		store_block(16'h0bad, BAD_OFF);
		live = 1'b1;
		store_block(16'h22, 1);
		op_push(5);
		emit_param(OP_BFALSE, 4);
		stack_pop(1);
		store_block(16'h33, 2);
		store_block(16'h44, 3);
		finish_program(5);
		release_and_wait("branch");

		// Load of preloaded words
		start_reset();
		mem['h800] = 20'h7abcd;
		mem['h801] = 20'hc0001;
		op_push('h800);
		emit_op(OP_LOAD);
		op_store_to(0, 20'h7abcd);
		flush_word();
		op_push('h801);
		emit_op(OP_LOAD);
		op_store_to(1, 20'hc0001);
		finish_program(6);
		release_and_wait("load");

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* lisp_core.f */
+incdir+tests
src/isa_pkg.sv
src/core_pkg.sv
src/insn_unit.sv
src/alu.sv
src/stack_datapath.sv
src/control_fsm.sv
src/lisp_core.sv
tests/tb_lisp_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_lisp_core
FILELIST  = lisp_core.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
